// File: source/fu_sto_cfg.svh
//------------------------------
// Widths and constants of the store-data formatter
// Exponent, fraction and bus bits are numbered from the MSB
// down, with the implicit bit as fraction bit 0
//------------------------------
`ifndef FU_STO_CFG_SVH
`define FU_STO_CFG_SVH

`define STO_EXPO_W 11
`define STO_FRAC_W 53
`define STO_DATA_W 64
`define STO_PAR_W 8

// Double bias 1023 less single bias 127
`define STO_SP_BIAS_ADJ 896
// Smallest exponent that still leaves a nonzero single denormal
`define STO_SP_DEN_MIN 874

`endif

// File: source/sto_pkg.sv
//------------------------------
// Types shared by the store-data formatter
// Vectors use ascending ranges, bit 0 is the MSB
// At most one store kind flag may be set
//------------------------------
`include "fu_sto_cfg.svh"

package sto_pkg;

   // Biased exponent, bit 1 is the MSB
   typedef logic [1:`STO_EXPO_W] expo_t;

   // Bit 0 holds the implicit bit
   typedef logic [0:`STO_FRAC_W-1] frac_t;

   typedef struct packed {
      logic dp;
      logic sp;
      logic wd;
   } sto_fmt_t;

   typedef logic [0:`STO_DATA_W-1] sto_data_t;

   typedef logic [0:`STO_DATA_W/2-1] sto_word_t;

   typedef logic [0:`STO_PAR_W-1] par_t;

endpackage

// File: source/sto_op_if.sv
//------------------------------
// Registered ex2 operand
// Payload holds while act is low
//------------------------------
`timescale 1ns/1ps

interface sto_op_if import sto_pkg::*;;

   logic     act;
   logic     sign;
   expo_t    expo;
   frac_t    frac;
   sto_fmt_t fmt;

   modport stage (
      output act, sign, expo, frac, fmt
   );

   modport user (
      input act, sign, expo, frac, fmt
   );

endinterface

// File: source/sto_operand_stage.sv
//------------------------------
// Ex1 to ex2 operand register
// Payload loads only with ex1_act
// and is not reset
//------------------------------
`timescale 1ns/1ps

module sto_operand_stage import sto_pkg::*; (
   input  logic     nclk,
   input  logic     rst,
   input  logic     ex1_act,
   input  sto_fmt_t ex1_fmt,
   input  logic     ex1_s_sign,
   input  expo_t    ex1_s_expo,
   input  frac_t    ex1_s_frac,
   sto_op_if.stage  op
);

   // The ex2 act gates every ex3 register downstream
   always_ff @(posedge nclk) begin
      if (rst) begin
         op.act <= 1'b0;
      end else begin
         op.act <= ex1_act;
      end
   end

   always_ff @(posedge nclk) begin
      if (ex1_act) begin
         op.fmt  <= ex1_fmt;
         op.sign <= ex1_s_sign;
         op.expo <= ex1_s_expo;
         op.frac <= ex1_s_frac;
      end
   end

endmodule

// File: source/sto_parity_check.sv
//------------------------------
// Operand parity compare
// Parity bits and the two extra exponent bits
// arrive from the register file in ex2
// Mismatch flag is valid in ex3
//------------------------------
`timescale 1ns/1ps

`include "fu_sto_cfg.svh"

module sto_parity_check import sto_pkg::*; (
   input  logic       nclk,
   input  logic       rst,
   sto_op_if.user     op,
   input  logic [1:0] ex2_s_expo_extra,
   input  par_t       ex2_s_par,
   output logic       ex3_s_parity_check
);

   par_t ex2_grp_par;
   logic ex2_par_err;

   always_comb begin
      // Group 0 covers the sign, the extra bits and the upper exponent
      ex2_grp_par[0] = op.sign ^ ex2_s_expo_extra[1] ^ ex2_s_expo_extra[0] ^
                       (^op.expo[1:7]);
      ex2_grp_par[1] = (^op.expo[8:11]) ^ (^op.frac[0:4]);
      // Remaining groups take the fraction eight bits at a time
      for (int g = 2; g < `STO_PAR_W; g++) begin
         ex2_grp_par[g] = ^op.frac[5 + 8 * (g - 2) +: 8];
      end
   end

   assign ex2_par_err = |(ex2_grp_par ^ ex2_s_par);

   always_ff @(posedge nclk) begin
      if (rst) begin
         ex3_s_parity_check <= 1'b0;
      end else if (op.act) begin
         ex3_s_parity_check <= ex2_par_err;
      end
   end

endmodule

// File: source/sto_single_conv.sv
//------------------------------
// Double to single conversion in ex2
// Operand must already be rounded to single, so
// exponents above the single range are not handled
// Exponents below the denormal range give a signed zero
//------------------------------
`timescale 1ns/1ps

`include "fu_sto_cfg.svh"

module sto_single_conv import sto_pkg::*; (
   sto_op_if.user    op,
   output sto_word_t ex2_sts_data
);

   logic        expo_ge897;
   logic        expo_eq896;
   logic        expo_ge874;
   logic [0:23] den_sh8;
   logic [0:23] den_sh4;
   logic [0:23] den_sh1;
   logic [0:23] den_frac;

   assign expo_ge897 = op.expo > `STO_SP_BIAS_ADJ;
   assign expo_eq896 = op.expo == `STO_SP_BIAS_ADJ;
   assign expo_ge874 = op.expo >= `STO_SP_DEN_MIN;

   // Shift is 897 minus the exponent, between 2 and 23 below 896.
   // In that range the low exponent bits give the amount in three
   // stages without a subtractor
   always_comb begin
      if (op.expo[7]) begin
         den_sh8 = {2'b0, op.frac[0:21]};
      end else begin
         den_sh8 = {18'b0, op.frac[0:5]};
      end
   end

   always_comb begin
      case (op.expo[8:9])
         2'b00:   den_sh4 = {12'b0, den_sh8[0:11]};
         2'b01:   den_sh4 = {8'b0, den_sh8[0:15]};
         2'b10:   den_sh4 = {4'b0, den_sh8[0:19]};
         default: den_sh4 = den_sh8;
      endcase
   end

   always_comb begin
      case (op.expo[10:11])
         2'b00:   den_sh1 = {3'b0, den_sh4[0:20]};
         2'b01:   den_sh1 = {2'b0, den_sh4[0:21]};
         2'b10:   den_sh1 = {1'b0, den_sh4[0:22]};
         default: den_sh1 = den_sh4;
      endcase
   end

   // Exponent 896 falls outside the decode above and shifts by one
   assign den_frac = expo_eq896 ? {1'b0, op.frac[0:22]} : den_sh1;

   always_comb begin
      if (expo_ge897) begin
         // MSB plus the low seven bits is the rebiased exponent over the
         // whole single range, and 2047 lands on 255
         ex2_sts_data = {op.sign, op.expo[1], op.expo[5:11], op.frac[1:23]};
      end else if (expo_ge874) begin
         ex2_sts_data = {op.sign, 8'b0, den_frac[1:23]};
      end else begin
         ex2_sts_data = {op.sign, 31'b0};
      end
   end

endmodule

// File: source/sto_result_stage.sv
//------------------------------
// Ex2 image build, ex3 register and bus placement
// Registers load only with the ex2 act
// Bus is zero when no store kind is set
//------------------------------
`timescale 1ns/1ps

module sto_result_stage import sto_pkg::*; (
   input  logic      nclk,
   sto_op_if.user    op,
   input  sto_word_t ex2_sts_data,
   output sto_data_t ex3_sto_data
);

   sto_data_t ex2_std_data;
   sto_data_t ex3_std_data;
   sto_word_t ex3_sts_data;
   sto_fmt_t  ex3_fmt;

   // A denormal carries exponent 1 with a zero implicit bit, and the
   // AND turns that into the zero field of the memory format.
   // Word stores reuse this image without the sign
   assign ex2_std_data = {op.sign & ~op.fmt.wd,
                          op.expo[1:10],
                          op.expo[11] & op.frac[0],
                          op.frac[1:52]};

   always_ff @(posedge nclk) begin
      if (op.act) begin
         ex3_std_data <= ex2_std_data;
         ex3_sts_data <= ex2_sts_data;
         ex3_fmt      <= op.fmt;
      end
   end

   // Word data sits in the low half of the image, fraction bits 21 to 52
   always_comb begin
      if (ex3_fmt.dp) begin
         ex3_sto_data = ex3_std_data;
      end else if (ex3_fmt.sp) begin
         ex3_sto_data = {ex3_sts_data, ex3_sts_data};
      end else if (ex3_fmt.wd) begin
         ex3_sto_data = {ex3_std_data[32:63], ex3_std_data[32:63]};
      end else begin
         ex3_sto_data = '0;
      end
   end

endmodule

// File: source/fu_sto.sv
//------------------------------
// Store-data formatter of the FPU
// Operand enters in ex1, parity in ex2,
// store data and parity flag leave in ex3
// No back-pressure, act low holds every stage
//------------------------------
`timescale 1ns/1ps

module fu_sto import sto_pkg::*; (
   input  logic       nclk,
   input  logic       rst,
   input  logic       ex1_act,
   input  logic       ex1_sto_dp,
   input  logic       ex1_sto_sp,
   input  logic       ex1_sto_wd,
   input  logic       ex1_s_sign,
   input  expo_t      ex1_s_expo,
   input  frac_t      ex1_s_frac,
   input  logic [1:0] ex2_s_expo_extra,
   input  par_t       ex2_s_par,
   output sto_data_t  ex3_sto_data,
   output logic       ex3_s_parity_check
);

   sto_fmt_t  ex1_fmt;
   sto_word_t ex2_sts_data;

   sto_op_if op ();

   assign ex1_fmt = '{dp: ex1_sto_dp, sp: ex1_sto_sp, wd: ex1_sto_wd};

   sto_operand_stage u_operand_stage (
      .nclk       (nclk),
      .rst        (rst),
      .ex1_act    (ex1_act),
      .ex1_fmt    (ex1_fmt),
      .ex1_s_sign (ex1_s_sign),
      .ex1_s_expo (ex1_s_expo),
      .ex1_s_frac (ex1_s_frac),
      .op         (op.stage)
   );

   sto_parity_check u_parity_check (
      .nclk               (nclk),
      .rst                (rst),
      .op                 (op.user),
      .ex2_s_expo_extra   (ex2_s_expo_extra),
      .ex2_s_par          (ex2_s_par),
      .ex3_s_parity_check (ex3_s_parity_check)
   );

   sto_single_conv u_single_conv (
      .op           (op.user),
      .ex2_sts_data (ex2_sts_data)
   );

   sto_result_stage u_result_stage (
      .nclk         (nclk),
      .op           (op.user),
      .ex2_sts_data (ex2_sts_data),
      .ex3_sto_data (ex3_sto_data)
   );

endmodule

// File: dv/fu_sto_tb.sv
//------------------------------
// Table-driven testbench of the store-data formatter
// Rows enter back to back and are checked two cycles later
// Parity is built from the group rule, corrupt rows flip one group
// The first mismatch ends the run
//------------------------------
`timescale 1ns/1ps

`include "fu_sto_cfg.svh"

module fu_sto_tb import sto_pkg::*; ();

   localparam int num_rows    = 24;
   localparam int reset_len   = 16;
   localparam int cycle_limit = reset_len + num_rows + 10;

   localparam sto_fmt_t fmt_dp   = '{dp: 1'b1, sp: 1'b0, wd: 1'b0};
   localparam sto_fmt_t fmt_sp   = '{dp: 1'b0, sp: 1'b1, wd: 1'b0};
   localparam sto_fmt_t fmt_wd   = '{dp: 1'b0, sp: 1'b0, wd: 1'b1};
   localparam sto_fmt_t fmt_none = '{dp: 1'b0, sp: 1'b0, wd: 1'b0};

   typedef struct packed {
      logic      act;
      sto_fmt_t  fmt;
      logic      sign;
      expo_t     expo;
      frac_t     frac;
      logic      corrupt;
      sto_data_t data;
   } row_t;

   logic       nclk;
   logic       rst;
   logic       ex1_act;
   logic       ex1_sto_dp;
   logic       ex1_sto_sp;
   logic       ex1_sto_wd;
   logic       ex1_s_sign;
   expo_t      ex1_s_expo;
   frac_t      ex1_s_frac;
   logic [1:0] ex2_s_expo_extra;
   par_t       ex2_s_par;
   sto_data_t  ex3_sto_data;
   logic       ex3_s_parity_check;

   row_t rows [num_rows];
   int   row_count = 0;
   int   cycle_count = 0;

   fu_sto u_dut (
      .nclk               (nclk),
      .rst                (rst),
      .ex1_act            (ex1_act),
      .ex1_sto_dp         (ex1_sto_dp),
      .ex1_sto_sp         (ex1_sto_sp),
      .ex1_sto_wd         (ex1_sto_wd),
      .ex1_s_sign         (ex1_s_sign),
      .ex1_s_expo         (ex1_s_expo),
      .ex1_s_frac         (ex1_s_frac),
      .ex2_s_expo_extra   (ex2_s_expo_extra),
      .ex2_s_par          (ex2_s_par),
      .ex3_sto_data       (ex3_sto_data),
      .ex3_s_parity_check (ex3_s_parity_check)
   );

   always #50 nclk = ~nclk;

   always @(posedge nclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Run stopped after %0d cycles before the table was done", cycle_count);
         $display("ERRORS FOUND");
         $fatal(1, "Timeout");
      end
   end

   // Groups in order cover sign, extra bits, exponent and fraction, MSB first
   function automatic par_t group_parity(input logic sign, input logic [1:0] extra,
                                         input expo_t expo, input frac_t frac);
      logic [0:66] bits;
      par_t        p;
      int          first;
      int          len;
      bits  = {sign, extra, expo, frac};
      p     = '0;
      first = 0;
      for (int g = 0; g < `STO_PAR_W; g++) begin
         len = (g == 0) ? 10 : ((g == 1) ? 9 : 8);
         for (int b = first; b < first + len; b++) begin
            p[g] = p[g] ^ bits[b];
         end
         first = first + len;
      end
      return p;
   endfunction

   task automatic add_row(input logic act, input sto_fmt_t fmt, input logic sign,
                          input expo_t expo, input frac_t frac, input logic corrupt,
                          input sto_data_t data);
      rows[row_count] = '{act, fmt, sign, expo, frac, corrupt, data};
      row_count++;
   endtask

   task automatic load_table();
      // Double stores, normal and denormal
      add_row(1'b1, fmt_dp,   1'b0, 11'h3ff, 53'h18_0000_0000_0000, 1'b0, 64'h3ff8_0000_0000_0000);
      add_row(1'b1, fmt_dp,   1'b1, 11'h400, 53'h10_0000_0000_0000, 1'b1, 64'hc000_0000_0000_0000);
      add_row(1'b1, fmt_dp,   1'b0, 11'h001, 53'h00_0000_0000_0001, 1'b0, 64'h0000_0000_0000_0001);
      add_row(1'b1, fmt_dp,   1'b1, 11'h001, 53'h08_0000_0000_0000, 1'b0, 64'h8008_0000_0000_0000);
      add_row(1'b1, fmt_dp,   1'b0, 11'h001, 53'h10_0000_0000_0000, 1'b1, 64'h0010_0000_0000_0000);
      // Single stores in the normal range, infinity and NaN
      add_row(1'b1, fmt_sp,   1'b0, 11'h3ff, 53'h18_0000_0000_0000, 1'b0, 64'h3fc0_0000_3fc0_0000);
      add_row(1'b1, fmt_sp,   1'b1, 11'h402, 53'h14_0000_0000_0000, 1'b0, 64'hc120_0000_c120_0000);
      add_row(1'b1, fmt_sp,   1'b0, 11'h381, 53'h10_0000_0000_0000, 1'b1, 64'h0080_0000_0080_0000);
      add_row(1'b1, fmt_sp,   1'b0, 11'h47e, 53'h1f_ffff_e000_0000, 1'b0, 64'h7f7f_ffff_7f7f_ffff);
      add_row(1'b1, fmt_sp,   1'b0, 11'h7ff, 53'h10_0000_0000_0000, 1'b0, 64'h7f80_0000_7f80_0000);
      add_row(1'b1, fmt_sp,   1'b1, 11'h7ff, 53'h18_0000_0000_0000, 1'b0, 64'hffc0_0000_ffc0_0000);
      // Single denormals, shifts of 1, 2, 7, 12, 17 and 23, then underflow
      add_row(1'b1, fmt_sp,   1'b0, 11'h380, 53'h10_0000_0000_0000, 1'b0, 64'h0040_0000_0040_0000);
      add_row(1'b1, fmt_sp,   1'b0, 11'h37f, 53'h18_0000_0000_0000, 1'b0, 64'h0030_0000_0030_0000);
      add_row(1'b1, fmt_sp,   1'b0, 11'h37a, 53'h10_0000_0000_0000, 1'b1, 64'h0001_0000_0001_0000);
      add_row(1'b1, fmt_sp,   1'b1, 11'h375, 53'h1a_0000_0000_0000, 1'b1, 64'h8000_0d00_8000_0d00);
      add_row(1'b1, fmt_sp,   1'b1, 11'h370, 53'h18_0000_0000_0000, 1'b0, 64'h8000_0060_8000_0060);
      add_row(1'b1, fmt_sp,   1'b0, 11'h36a, 53'h18_0000_0000_0000, 1'b0, 64'h0000_0001_0000_0001);
      add_row(1'b1, fmt_sp,   1'b1, 11'h369, 53'h1f_ffff_ffff_ffff, 1'b0, 64'h8000_0000_8000_0000);
      // Word stores ignore the sign
      add_row(1'b1, fmt_wd,   1'b1, 11'h433, 53'h10_0000_1234_5678, 1'b1, 64'h1234_5678_1234_5678);
      add_row(1'b1, fmt_wd,   1'b0, 11'h41e, 53'h10_abcd_dead_beef, 1'b0, 64'hdead_beef_dead_beef);
      // Idle row holds the previous result and flag
      add_row(1'b0, fmt_dp,   1'b1, 11'h400, 53'h10_0000_0000_0000, 1'b1, 64'hdead_beef_dead_beef);
      add_row(1'b1, fmt_sp,   1'b0, 11'h3ff, 53'h18_0000_0000_0000, 1'b1, 64'h3fc0_0000_3fc0_0000);
      add_row(1'b1, fmt_none, 1'b1, 11'h3ff, 53'h10_0000_0000_0000, 1'b0, 64'h0000_0000_0000_0000);
      add_row(1'b1, fmt_dp,   1'b0, 11'h3ff, 53'h18_0000_0000_0000, 1'b0, 64'h3ff8_0000_0000_0000);
   endtask

   task automatic drive_ex1(input int r);
      ex1_act    = rows[r].act;
      ex1_sto_dp = rows[r].fmt.dp;
      ex1_sto_sp = rows[r].fmt.sp;
      ex1_sto_wd = rows[r].fmt.wd;
      ex1_s_sign = rows[r].sign;
      ex1_s_expo = rows[r].expo;
      ex1_s_frac = rows[r].frac;
   endtask

   task automatic drive_idle_ex1();
      ex1_act    = 1'b0;
      ex1_sto_dp = 1'b0;
      ex1_sto_sp = 1'b0;
      ex1_sto_wd = 1'b0;
      ex1_s_sign = 1'b0;
      ex1_s_expo = '0;
      ex1_s_frac = '0;
   endtask

   // Register-file parity for the row now in ex2
   task automatic drive_ex2(input int r);
      logic [1:0] extra;
      par_t       p;
      int         g;
      extra = 2'($urandom_range(3, 0));
      p     = group_parity(rows[r].sign, extra, rows[r].expo, rows[r].frac);
      if (rows[r].corrupt) begin
         g    = $urandom_range(7, 0);
         p[g] = ~p[g];
      end
      ex2_s_expo_extra = extra;
      ex2_s_par        = p;
   endtask

   task automatic drive_idle_ex2();
      ex2_s_expo_extra = 2'b00;
      ex2_s_par        = '0;
   endtask

   task automatic check_data(input int row, input sto_data_t got, input sto_data_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: row %0d store data %h, expected %h", $time, row, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "Store data mismatch");
      end
   endtask

   task automatic check_par(input int row, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at %0t ns: row %0d parity flag %b, expected %b", $time, row, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "Parity flag mismatch");
      end
   endtask

   initial begin
      int   r;
      logic exp_flag;
      void'($urandom(67016));
      nclk = 1'b0;
      rst  = 1'b1;
      drive_idle_ex1();
      drive_idle_ex2();
      load_table();
      exp_flag = 1'b0;
      repeat (reset_len) @(negedge nclk);
      rst = 1'b0;
      for (int n = 0; n < num_rows + 2; n++) begin
         if (n >= 2) begin
            r = n - 2;
            // An idle row leaves the flag of the last active row
            if (rows[r].act) begin
               exp_flag = rows[r].corrupt;
            end
            check_data(r, ex3_sto_data, rows[r].data);
            check_par(r, ex3_s_parity_check, exp_flag);
         end
         if (n >= 1 && n <= num_rows) begin
            drive_ex2(n - 1);
         end else begin
            drive_idle_ex2();
         end
         if (n < num_rows) begin
            drive_ex1(n);
         end else begin
            drive_idle_ex1();
         end
         @(negedge nclk);
      end
      if (row_count == num_rows) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         $display("Table holds %0d rows but the run applied %0d", row_count, num_rows);
         $display("ERRORS FOUND");
         $fatal(1, "Table size mismatch");
      end
   end

endmodule

// File: tb.f
+incdir+source
source/sto_pkg.sv
source/sto_op_if.sv
source/sto_operand_stage.sv
source/sto_parity_check.sv
source/sto_single_conv.sv
source/sto_result_stage.sv
source/fu_sto.sv
dv/fu_sto_tb.sv

// File: Makefile
# Verilator flow for the store-data formatter testbench.
# The simulation exits with a failing status when a check fails.

TOP := fu_sto_tb

SOURCES := tb.f $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f tb.f --top-module fu_sto
	verilator --lint-only --timing --timescale 1ns/1ps -f tb.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps -j 0 -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
